// File: hdc_defines.svh
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// hypervector width, the rotate decode assumes 1024
`define HV_DIM 1024

// item memory entries per core
`define ITEM_DEPTH 1024

// shared result box entries
`define BOX_DEPTH 16

// number of peer cores
`define N_CORES 2

`endif

// File: hdc_pkg.sv
`include "hdc_defines.svh"

package hdc_pkg;

    // addressed form, bit 15 set
    typedef struct packed {
        logic                             addr_form;
        logic                             load;
        logic                             load_xor;
        logic                             wb;
        logic [1:0]                       rsvd;
        logic [$clog2(`ITEM_DEPTH)-1:0]   addr;
    } hdc_addr_inst_t;

    // register form, bit 15 clear
    // sel[9] is bit 12 of the word
    typedef struct packed {
        logic       addr_form;
        logic       rot_r;
        logic       rot_l;
        logic [9:0] sel;
        logic [2:0] rsvd;
    } hdc_reg_inst_t;

    typedef union packed {
        hdc_addr_inst_t a;
        hdc_reg_inst_t  r;
    } hdc_inst_u;

    // positions inside sel when no rotate is given, highest priority first
    localparam int SEL_XOR   = 9;
    localparam int SEL_STORE = 8;
    localparam int SEL_LAST  = 7;
    localparam int SEL_MOVE  = 6;
    localparam int SEL_SIGN  = 5;

    // one pending store, also the layout of a box entry
    typedef struct packed {
        logic [`HV_DIM-1:0]              vec;
        logic                            last;
        logic [$clog2(`N_CORES)-1:0]     core;
    } store_req_t;

endpackage

// File: hv_store_if.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

interface hv_store_if;
    // one-cycle strobe qualifying result
    logic                 store;
    logic [`HV_DIM-1:0]   result;
    logic                 last;
    // sticky, held until run drops
    logic                 overflow;

    modport core (
        output store,
        output result,
        output last,
        input  overflow
    );

    modport arb (
        input  store,
        input  result,
        input  last,
        output overflow
    );
endinterface

// File: hdc_core.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_core (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             run,
    input  logic                             gen,
    input  logic                             update_item,
    input  logic [$clog2(`ITEM_DEPTH)-1:0]   item_a,
    input  logic [`HV_DIM-1:0]               rand_num,
    input  logic                             get_v,
    input  logic [15:0]                      get_d,
    input  logic                             exec,
    input  logic [`HV_DIM-1:0]               sign_vec,
    hv_store_if.core                         st
);
    localparam int AW = $clog2(`ITEM_DEPTH);

    logic [`HV_DIM-1:0]     item_mem [`ITEM_DEPTH];
    logic [`HV_DIM-1:0]     item_rd;
    logic                   fwd;

    hdc_pkg::hdc_inst_u     in_w;
    hdc_pkg::hdc_inst_u     inst;
    logic                   wb_flag;
    logic [AW-1:0]          wb_addr;

    logic [`HV_DIM-1:0]     reg_0;
    logic [`HV_DIM-1:0]     reg_1;
    logic [`HV_DIM-1:0]     reg_2;
    logic [`HV_DIM-1:0]     buff;
    logic                   store_q;
    logic                   last_q;

    logic                   do_load;
    logic                   do_lxor;
    logic                   do_rot_r;
    logic                   do_rot_l;
    logic                   do_xor;
    logic                   do_store;
    logic                   do_last;
    logic                   do_move;
    logic                   do_sign;

    logic [9:0]             shamt;
    logic [2*`HV_DIM-1:0]   dbl_r;
    logic [2*`HV_DIM-1:0]   dbl_l;

    assign in_w = get_d;

    // item memory, write-back wins over random fill
    always_ff @(posedge clk) begin
        if (wb_flag) begin
            item_mem[wb_addr] <= reg_2;
        end else if (gen && update_item) begin
            item_mem[item_a] <= rand_num;
        end
        // read every cycle at the incoming address
        item_rd <= item_mem[in_w.a.addr];
    end

    // instruction register and pending write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst    <= '0;
            wb_flag <= 1'b0;
            wb_addr <= '0;
            fwd     <= 1'b0;
        end else begin
            // a load right after wb sees reg_2, not the stale entry
            fwd <= wb_flag && (wb_addr == in_w.a.addr);
            if (get_v && in_w.a.addr_form && in_w.a.wb) begin
                // wb issues a nop into the pipe
                inst    <= '0;
                wb_flag <= 1'b1;
                wb_addr <= in_w.a.addr;
            end else if (get_v) begin
                inst    <= in_w;
                wb_flag <= 1'b0;
            end else begin
                inst    <= '0;
                wb_flag <= 1'b0;
            end
        end
    end

    assign reg_0 = fwd ? reg_2 : item_rd;

    // priority decode of the held word
    always_comb begin
        do_load  = 1'b0;
        do_lxor  = 1'b0;
        do_rot_r = 1'b0;
        do_rot_l = 1'b0;
        do_xor   = 1'b0;
        do_store = 1'b0;
        do_last  = 1'b0;
        do_move  = 1'b0;
        do_sign  = 1'b0;
        if (inst.a.addr_form) begin
            if (inst.a.load)
                do_load = 1'b1;
            else if (inst.a.load_xor)
                do_lxor = 1'b1;
        end else if (inst.r.rot_r) begin
            do_rot_r = 1'b1;
        end else if (inst.r.rot_l) begin
            do_rot_l = 1'b1;
        end else if (inst.r.sel[hdc_pkg::SEL_XOR]) begin
            do_xor = 1'b1;
        end else if (inst.r.sel[hdc_pkg::SEL_STORE]) begin
            do_store = 1'b1;
        end else if (inst.r.sel[hdc_pkg::SEL_LAST]) begin
            do_last = 1'b1;
        end else if (inst.r.sel[hdc_pkg::SEL_MOVE]) begin
            do_move = 1'b1;
        end else if (inst.r.sel[hdc_pkg::SEL_SIGN]) begin
            do_sign = 1'b1;
        end
    end

    // shift amount from the one-hot field, sel[9] means 1
    always_comb begin
        shamt = '0;
        for (int k = 0; k < 10; k++) begin
            if (inst.r.sel[k])
                shamt = 10'd1 << (9 - k);
        end
    end

    // rotate through a doubled copy
    assign dbl_r = {reg_2, reg_2} >> shamt;
    assign dbl_l = {reg_2, reg_2} << shamt;

    // register file, cleared while idle
    always_ff @(posedge clk) begin
        if (!run) begin
            reg_1 <= '0;
            reg_2 <= '0;
        end else if (exec) begin
            if (do_load)
                reg_2 <= reg_0;
            else if (do_lxor)
                reg_2 <= reg_0 ^ reg_2;
            else if (do_rot_r)
                reg_2 <= dbl_r[`HV_DIM-1:0];
            else if (do_rot_l)
                reg_2 <= dbl_l[2*`HV_DIM-1:`HV_DIM];
            else if (do_xor)
                reg_2 <= reg_1 ^ reg_2;
            else if (do_sign)
                reg_2 <= sign_vec;
            if (do_move)
                reg_1 <= reg_2;
            if (do_store)
                buff <= reg_2;
        end
    end

    // store strobe, last holds until run drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (!run) begin
            store_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            store_q <= exec && do_store;
            if (exec && do_last)
                last_q <= 1'b1;
        end
    end

    assign st.store  = store_q;
    assign st.result = buff;
    assign st.last   = last_q;

    rot_amount_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (run && exec && (do_rot_r || do_rot_l)) |-> $onehot0(inst.r.sel)
    ) else $error("rotate with several amount bits: %h", inst.r.sel);

endmodule

// File: store_arbiter.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module store_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    hv_store_if.arb                c0,
    hv_store_if.arb                c1,
    output logic                   box_we,
    output hdc_pkg::store_req_t    box_wdata
);
    hdc_pkg::store_req_t    slot [`N_CORES];
    hdc_pkg::store_req_t    req [`N_CORES];
    logic [`N_CORES-1:0]    pulse;
    logic [`N_CORES-1:0]    full;
    logic [`N_CORES-1:0]    ovf;
    logic [`N_CORES-1:0]    grant_oh;
    logic                   grant_idx;
    logic                   last_grant;

    assign pulse  = {c1.store, c0.store};
    assign req[0] = '{vec: c0.result, last: c0.last, core: 1'b0};
    assign req[1] = '{vec: c1.result, last: c1.last, core: 1'b1};

    // round robin only matters when both wait
    always_comb begin
        if (full == 2'b11)
            grant_idx = ~last_grant;
        else
            grant_idx = full[1];
    end

    assign box_we    = run && (|full);
    assign grant_oh  = box_we ? (grant_idx ? 2'b10 : 2'b01) : 2'b00;
    assign box_wdata = slot[grant_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full       <= '0;
            ovf        <= '0;
            last_grant <= 1'b1;
        end else if (!run) begin
            full       <= '0;
            ovf        <= '0;
            // core 0 goes first after run rises
            last_grant <= 1'b1;
        end else begin
            full <= (full & ~grant_oh) | pulse;
            // a pulse into an occupied slot is an overflow
            ovf  <= ovf | (pulse & full);
            if (box_we)
                last_grant <= grant_idx;
        end
    end

    // new request lands when the slot is free or drains now
    always_ff @(posedge clk) begin
        for (int i = 0; i < `N_CORES; i++) begin
            if (pulse[i] && (!full[i] || grant_oh[i]))
                slot[i] <= req[i];
        end
    end

    assign c0.overflow = ovf[0];
    assign c1.overflow = ovf[1];

    // every box write comes from a store seen in the last two cycles
    we_has_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        box_we |-> $past(|pulse, 1) || $past(|pulse, 2)
    ) else $error("box write with no recent store, full=%b", full);

    // the same slot is not written twice without a new store
    grant_empties: assert property (
        @(posedge clk) disable iff (!rst_n)
        box_we && (pulse & grant_oh) == '0 |=> !box_we || grant_oh != $past(grant_oh)
    ) else $error("granted slot still full, full=%b", full);

endmodule

// File: result_box.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module result_box (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              box_we,
    input  hdc_pkg::store_req_t               box_wdata,
    input  logic [$clog2(`BOX_DEPTH)-1:0]     raddr,
    output hdc_pkg::store_req_t               rdata,
    output logic [$clog2(`BOX_DEPTH+1)-1:0]   count
);
    localparam int AW = $clog2(`BOX_DEPTH);

    hdc_pkg::store_req_t    mem [`BOX_DEPTH];
    logic [AW-1:0]          wptr;

    // pointer and fill level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            count <= '0;
        end else if (!run) begin
            wptr  <= '0;
            count <= '0;
        end else if (box_we) begin
            wptr <= wptr + 1'b1;
            if (count != `BOX_DEPTH)
                count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (box_we)
            mem[wptr] <= box_wdata;
    end

    // asynchronous read port
    assign rdata = mem[raddr];

    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        box_we |-> count < `BOX_DEPTH
    ) else $error("write into full result box, count=%h", count);

endmodule

// File: hv_bundler.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hv_bundler (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              box_we,
    input  hdc_pkg::store_req_t               box_wdata,
    input  logic [$clog2(`BOX_DEPTH+1)-1:0]   count,
    output logic [`HV_DIM-1:0]                sign_vec
);
    localparam int CW = $clog2(`BOX_DEPTH + 1);

    // ones seen per bit position
    logic [CW-1:0]  ones [`HV_DIM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `HV_DIM; i++)
                ones[i] <= '0;
        end else if (!run) begin
            for (int i = 0; i < `HV_DIM; i++)
                ones[i] <= '0;
        end else if (box_we) begin
            for (int i = 0; i < `HV_DIM; i++) begin
                // saturate like the box count
                if (box_wdata.vec[i] && ones[i] != `BOX_DEPTH)
                    ones[i] <= ones[i] + 1'b1;
            end
        end
    end

    // majority, ties give 0
    always_comb begin
        for (int i = 0; i < `HV_DIM; i++)
            sign_vec[i] = {ones[i], 1'b0} > {1'b0, count};
    end

endmodule

// File: hdc_top.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              gen,
    input  logic [`N_CORES-1:0]               update_item,
    input  logic [$clog2(`ITEM_DEPTH)-1:0]    item_a,
    input  logic [`HV_DIM-1:0]                rand_num,
    input  logic [`N_CORES-1:0]               get_v,
    input  logic [15:0]                       get_d0,
    input  logic [15:0]                       get_d1,
    input  logic [`N_CORES-1:0]               exec,
    input  logic [$clog2(`BOX_DEPTH)-1:0]     box_raddr,
    output hdc_pkg::store_req_t               box_rdata,
    output logic [$clog2(`BOX_DEPTH+1)-1:0]   box_count,
    output logic [`N_CORES-1:0]               last,
    output logic [`N_CORES-1:0]               overflow
);
    hv_store_if st0 ();
    hv_store_if st1 ();

    logic                   box_we;
    hdc_pkg::store_req_t    box_wdata;
    logic [`HV_DIM-1:0]     sign_vec;

    hdc_core u_core0 (
        .clk(clk), .rst_n(rst_n), .run(run), .gen(gen),
        .update_item(update_item[0]), .item_a(item_a), .rand_num(rand_num),
        .get_v(get_v[0]), .get_d(get_d0), .exec(exec[0]),
        .sign_vec(sign_vec), .st(st0.core)
    );

    hdc_core u_core1 (
        .clk(clk), .rst_n(rst_n), .run(run), .gen(gen),
        .update_item(update_item[1]), .item_a(item_a), .rand_num(rand_num),
        .get_v(get_v[1]), .get_d(get_d1), .exec(exec[1]),
        .sign_vec(sign_vec), .st(st1.core)
    );

    store_arbiter u_arb (
        .clk(clk), .rst_n(rst_n), .run(run),
        .c0(st0.arb), .c1(st1.arb),
        .box_we(box_we), .box_wdata(box_wdata)
    );

    result_box u_box (
        .clk(clk), .rst_n(rst_n), .run(run),
        .box_we(box_we), .box_wdata(box_wdata),
        .raddr(box_raddr), .rdata(box_rdata), .count(box_count)
    );

    // bundler follows the same write strobe as the box
    hv_bundler u_bundler (
        .clk(clk), .rst_n(rst_n), .run(run),
        .box_we(box_we), .box_wdata(box_wdata),
        .count(box_count), .sign_vec(sign_vec)
    );

    assign last     = {st1.last, st0.last};
    assign overflow = {st1.overflow, st0.overflow};

endmodule

// File: tb_hdc_top.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module tb_hdc_top;
    localparam int N_TESTS = 6;
    localparam int TEST_CYCLES = 100;
    localparam int WATCHDOG_CYCLES = 8 + N_TESTS * TEST_CYCLES + 100;
    localparam int WAIT_LIMIT = 32;

    localparam logic [15:0] OP_LOAD  = 16'hC000;
    localparam logic [15:0] OP_LXOR  = 16'hA000;
    localparam logic [15:0] OP_WB    = 16'h9000;
    localparam logic [15:0] OP_ROR   = 16'h4000;
    localparam logic [15:0] OP_ROL   = 16'h2000;
    localparam logic [15:0] OP_XOR   = 16'h1000;
    localparam logic [15:0] OP_STORE = 16'h0800;
    localparam logic [15:0] OP_LAST  = 16'h0400;
    localparam logic [15:0] OP_MOVE  = 16'h0200;
    localparam logic [15:0] OP_SIGN  = 16'h0100;

    logic                             clk;
    logic                             rst_n;
    logic                             run;
    logic                             gen;
    logic [1:0]                       update_item;
    logic [$clog2(`ITEM_DEPTH)-1:0]   item_a;
    logic [`HV_DIM-1:0]               rand_num;
    logic [1:0]                       get_v;
    logic [15:0]                      get_d0;
    logic [15:0]                      get_d1;
    logic [1:0]                       exec;
    logic [$clog2(`BOX_DEPTH)-1:0]    box_raddr;
    hdc_pkg::store_req_t              box_rdata;
    logic [$clog2(`BOX_DEPTH+1)-1:0]  box_count;
    logic [1:0]                       last;
    logic [1:0]                       overflow;

    logic [15:0]          lfsr_state;
    logic [`HV_DIM-1:0]   vec_a;
    logic [`HV_DIM-1:0]   vec_b;
    logic [`HV_DIM-1:0]   vec_c;
    int                   errors;
    int                   checks;
    int                   test_errors;
    int                   tests_run;

    hdc_top dut (
        .clk(clk), .rst_n(rst_n), .run(run), .gen(gen), .update_item(update_item),
        .item_a(item_a), .rand_num(rand_num), .get_v(get_v), .get_d0(get_d0),
        .get_d1(get_d1), .exec(exec), .box_raddr(box_raddr), .box_rdata(box_rdata),
        .box_count(box_count), .last(last), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic make_random_vector(output logic [`HV_DIM-1:0] v);
        for (int i = 0; i < `HV_DIM; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [`HV_DIM-1:0] rotate_right(input logic [`HV_DIM-1:0] v, input int s);
        return (v >> s) | (v << (`HV_DIM - s));
    endfunction

    function automatic logic [`HV_DIM-1:0] rotate_left(input logic [`HV_DIM-1:0] v, input int s);
        return (v << s) | (v >> (`HV_DIM - s));
    endfunction

    // one-hot amount field, bit 12 is a shift of 1
    function automatic logic [15:0] rot_amount(input int log2_shift);
        return 16'h1000 >> log2_shift;
    endfunction

    task automatic expect_vec(input string name, input logic [`HV_DIM-1:0] got,
                              input logic [`HV_DIM-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_bits(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("%s", what);
    endtask

    task automatic issue(input logic [1:0] v, input logic [15:0] w0, input logic [15:0] w1);
        @(posedge clk);
        get_v  <= v;
        get_d0 <= w0;
        get_d1 <= w1;
    endtask

    task automatic fill_item(input logic [1:0] cores, input logic [9:0] addr,
                             input logic [`HV_DIM-1:0] v);
        @(posedge clk);
        gen         <= 1'b1;
        update_item <= cores;
        item_a      <= addr;
        rand_num    <= v;
        @(posedge clk);
        gen         <= 1'b0;
        update_item <= 2'b00;
    endtask

    task automatic wait_box_count(input int n);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (box_count != n && cycles < WAIT_LIMIT);
        if (box_count != n)
            note_failure($sformatf("box count never reached %0d", n));
    endtask

    task automatic read_box_entry(input logic [3:0] idx, output hdc_pkg::store_req_t d);
        @(posedge clk);
        box_raddr <= idx;
        @(negedge clk);
        d = box_rdata;
    endtask

    // run low for one edge empties the box and clears the cores
    task automatic start_test();
        test_errors = 0;
        tests_run++;
        @(posedge clk);
        run <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    task automatic test_fill_store();
        hdc_pkg::store_req_t e;
        start_test();
        make_random_vector(vec_a);
        make_random_vector(vec_b);
        fill_item(2'b01, 10'd3, vec_a);
        fill_item(2'b01, 10'd7, vec_b);
        issue(2'b01, OP_LOAD | 16'd3, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(1);
        read_box_entry(4'd0, e);
        expect_vec("box_rdata.vec", e.vec, vec_a);
        expect_bits("box_rdata.core", e.core, 0);
        // load of item 7 is skipped while exec is low, so item 3 stays
        issue(2'b01, OP_LOAD | 16'd7, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        exec <= 2'b10;
        issue(2'b00, 16'h0, 16'h0);
        exec <= 2'b11;
        wait_box_count(2);
        read_box_entry(4'd1, e);
        expect_vec("box_rdata.vec", e.vec, vec_a);
        report_test("fill and store");
    endtask

    task automatic test_operations();
        hdc_pkg::store_req_t e;
        logic [`HV_DIM-1:0] expected;
        start_test();
        expected = vec_a ^ rotate_left(rotate_right(vec_a ^ vec_b, 4), 1);
        issue(2'b01, OP_LOAD | 16'd3, 16'h0);
        issue(2'b01, OP_MOVE, 16'h0);
        issue(2'b01, OP_LXOR | 16'd7, 16'h0);
        issue(2'b01, OP_ROR | rot_amount(2), 16'h0);
        issue(2'b01, OP_ROL | rot_amount(0), 16'h0);
        issue(2'b01, OP_XOR, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(1);
        read_box_entry(4'd0, e);
        expect_vec("box_rdata.vec", e.vec, expected);
        report_test("operations");
    endtask

    task automatic test_writeback_forward();
        hdc_pkg::store_req_t e;
        logic [`HV_DIM-1:0] rotated;
        start_test();
        rotated = rotate_left(vec_a, 8);
        issue(2'b01, OP_LOAD | 16'd3, 16'h0);
        issue(2'b01, OP_ROL | rot_amount(3), 16'h0);
        issue(2'b01, OP_WB | 16'd9, 16'h0);
        issue(2'b01, OP_LOAD | 16'd9, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(1);
        read_box_entry(4'd0, e);
        expect_vec("box_rdata.vec", e.vec, rotated);
        // other value in the register first, then item 9 from memory
        issue(2'b01, OP_LOAD | 16'd7, 16'h0);
        issue(2'b01, OP_LOAD | 16'd9, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(2);
        read_box_entry(4'd1, e);
        expect_vec("box_rdata.vec", e.vec, rotated);
        report_test("write-back forwarding");
    endtask

    task automatic test_shared_box();
        hdc_pkg::store_req_t e0;
        hdc_pkg::store_req_t e1;
        start_test();
        make_random_vector(vec_c);
        fill_item(2'b10, 10'd5, vec_c);
        issue(2'b11, OP_LOAD | 16'd3, OP_LOAD | 16'd5);
        issue(2'b11, OP_STORE, OP_STORE);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(2);
        read_box_entry(4'd0, e0);
        read_box_entry(4'd1, e1);
        checks++;
        if (!((e0.vec === vec_a && e1.vec === vec_c) ||
              (e0.vec === vec_c && e1.vec === vec_a))) begin
            errors++;
            test_errors++;
            $display("Error: box_rdata.vec entries are %h and %h, expected %h and %h",
                     e0.vec, e1.vec, vec_a, vec_c);
        end
        report_test("shared box");
    endtask

    task automatic test_majority();
        hdc_pkg::store_req_t e;
        logic [`HV_DIM-1:0] x;
        logic [`HV_DIM-1:0] y;
        logic [`HV_DIM-1:0] z;
        start_test();
        make_random_vector(x);
        make_random_vector(y);
        make_random_vector(z);
        fill_item(2'b01, 10'd20, x);
        fill_item(2'b01, 10'd21, y);
        fill_item(2'b01, 10'd22, z);
        for (int i = 0; i < 3; i++) begin
            issue(2'b01, OP_LOAD | 16'(20 + i), 16'h0);
            issue(2'b01, OP_STORE, 16'h0);
        end
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(3);
        issue(2'b01, OP_SIGN, 16'h0);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(4);
        read_box_entry(4'd3, e);
        // two of three ones per bit
        expect_vec("box_rdata.vec", e.vec, (x & y) | (x & z) | (y & z));
        report_test("majority");
    endtask

    task automatic test_overflow_last();
        hdc_pkg::store_req_t e;
        int cycles;
        start_test();
        issue(2'b01, OP_LOAD | 16'd3, 16'h0);
        issue(2'b11, OP_STORE, OP_STORE);
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b01, OP_LAST, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(overflow[0] && last[0]) && cycles < WAIT_LIMIT);
        if (!(overflow[0] && last[0]))
            note_failure("overflow[0] or last[0] never rose after back-to-back stores");
        expect_bits("overflow[1]", overflow[1], 0);
        expect_bits("last[1]", last[1], 0);
        wait_box_count(3);
        // last is sticky and rides along with the next store
        issue(2'b01, OP_STORE, 16'h0);
        issue(2'b00, 16'h0, 16'h0);
        wait_box_count(4);
        read_box_entry(4'd1, e);
        expect_bits("box_rdata.core", e.core, 1);
        expect_bits("box_rdata.last", e.last, 0);
        read_box_entry(4'd3, e);
        expect_bits("box_rdata.last", e.last, 1);
        @(posedge clk);
        run <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        expect_bits("box_count", box_count, 0);
        expect_bits("overflow", overflow, 0);
        expect_bits("last", last, 0);
        report_test("overflow and last");
    endtask

    initial begin
        rst_n       = 1'b0;
        run         = 1'b0;
        gen         = 1'b0;
        update_item = 2'b00;
        item_a      = '0;
        rand_num    = '0;
        get_v       = 2'b00;
        get_d0      = 16'h0;
        get_d1      = 16'h0;
        exec        = 2'b11;
        box_raddr   = '0;
        lfsr_state  = 16'd63947;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        tests_run   = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_fill_store();
        test_operations();
        test_writeback_forward();
        test_shared_box();
        test_majority();
        test_overflow_last();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: all.f
+incdir+.
hdc_pkg.sv
hv_store_if.sv
hdc_core.sv
store_arbiter.sv
result_box.sv
hv_bundler.sv
hdc_top.sv
tb_hdc_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module tb_hdc_top -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
